/* compile.f */
rtl/hart_mem_pkg.sv
rtl/hart_bus_router.sv
rtl/unified_ram.sv
rtl/debug_apb_master.sv
rtl/hart_mem_top.sv
testbench/hart_mem_sva.sv
testbench/hart_mem_tb.sv

/* Bender.yml */
package:
  name: hart_mem

sources:
  # Design, package first
  - rtl/hart_mem_pkg.sv
  - rtl/hart_bus_router.sv
  - rtl/unified_ram.sv
  - rtl/debug_apb_master.sv
  - rtl/hart_mem_top.sv
  # Bound assertions and testbench top
  - target: test
    files:
      - testbench/hart_mem_sva.sv
      - testbench/hart_mem_tb.sv

/* testbench/hart_mem_tb.sv */
/* Testbench for the hart memory fabric: APB slave model, reference
   model, directed and random traffic on both hart ports */
`timescale 1ns/100ps

module hart_mem_tb;
  import hart_mem_pkg::*;

  logic            clk;
  logic            reset_n;
  imem_req_t       imem;
  dmem_req_t       dmem;
  logic            debug_mode;
  apb_rsp_t        apb_rsp;
  mem_rsp_t        imem_rsp;
  mem_rsp_t        dmem_rsp;
  apb_req_t        apb_req;
  logic [XLEN-1:0] tohost;

  // Reference state
  logic [XLEN-1:0]   shadow_ram [RAM_WORDS];
  logic [XLEN-1:0]   apb_mem [1024];
  logic [XLEN-1:0]   tohost_shadow;

  // Outstanding request per port with index 1 for the data port
  logic              pend      [2];
  mem_rsp_t          exp_rsp   [2];
  logic              exp_write [2];
  target_e           exp_tgt   [2];
  int                exp_lat   [2];
  int                issue_cyc [2];
  int                done_cyc  [2];
  logic [XLEN-1:0]   exp_addr  [2];
  logic [XLEN-1:0]   exp_wdata [2];
  // RAM reads must take exactly 2 cycles
  logic              strict_lat;
  int                cyc;
  int                errors;
  int                checks;
  int                tests;
  int                test_err0;

  // APB slave model
  logic              in_access;
  int                wait_left;
  logic [APB_AW-1:0] last_paddr;
  logic              last_pwrite;
  logic [XLEN-1:0]   last_pwdata;

  hart_mem_top u_dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_imem       (imem),
    .i_dmem       (dmem),
    .i_debug_mode (debug_mode),
    .i_apb        (apb_rsp),
    .o_imem_rsp   (imem_rsp),
    .o_dmem_rsp   (dmem_rsp),
    .o_apb        (apb_req),
    .o_tohost     (tohost)
  );

  always #20 clk = ~clk;

  // ============================================================
  //  Reference model
  // ============================================================
  function automatic target_e ref_target(input logic [XLEN-1:0] addr, input logic dbg,
                                         input logic dport);
    if (dbg && (addr >= 32'h200) && (addr <= 32'hFFF))
      return DEBUG;
    // Base window or the all-ones alias
    if ((addr[XLEN-1:RAM_OFS_BITS] == RAM_BASE[XLEN-1:RAM_OFS_BITS]) ||
        (addr[XLEN-1:RAM_OFS_BITS] == {(XLEN-RAM_OFS_BITS){1'b1}}))
      return RAM;
    if (dport && (addr == TOHOST_ADDR))
      return TOHOST;
    return UNMAPPED;
  endfunction

  function automatic mem_rsp_t ref_rsp(input logic [XLEN-1:0] addr, input logic dbg,
                                       input logic dport);
    mem_rsp_t r;
    r = '{done: 1'b1, err: 1'b0, rdata: '0};
    case (ref_target(addr, dbg, dport))
      RAM:
        r.rdata = shadow_ram[addr[RAM_OFS_BITS-1:2]];
      DEBUG:
      begin
        // Slave flags 0xFFC and returns zero data there
        if (addr[APB_AW-1:0] == 13'hFFC)
          r.err = 1'b1;
        else
          r.rdata = apb_mem[addr[11:2]];
      end
      TOHOST:
        r.rdata = tohost_shadow;
      default:
        r.err = 1'b1;
    endcase
    return r;
  endfunction

  // ============================================================
  //  APB slave with 0 to 3 wait states per transfer
  // ============================================================
  always @(negedge clk)
  begin
    apb_rsp = '0;
    if (apb_req.psel && apb_req.penable)
    begin
      if (!in_access)
      begin
        in_access = 1'b1;
        wait_left = $urandom % 4;
      end
      if (wait_left == 0)
      begin
        apb_rsp.pready = 1'b1;
        last_paddr     = apb_req.paddr;
        last_pwrite    = apb_req.pwrite;
        last_pwdata    = apb_req.pwdata;
        in_access      = 1'b0;
        if (apb_req.paddr == 13'hFFC)
          apb_rsp.pslverr = 1'b1;
        else if (apb_req.pwrite)
          apb_mem[apb_req.paddr[11:2]] = apb_req.pwdata;
        else
          apb_rsp.prdata = apb_mem[apb_req.paddr[11:2]];
      end
      else
        wait_left--;
    end
  end

  // ============================================================
  //  Checking
  // ============================================================
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic compare_port(input logic dport, input mem_rsp_t rsp);
    string pn;
    pn = dport ? "dmem_rsp" : "imem_rsp";
    if (rsp.done)
    begin
      if (!pend[dport])
      begin
        errors++;
        $display("ERROR: %s done pulsed with no request outstanding", pn);
      end
      else
      begin
        pend[dport]     = 1'b0;
        done_cyc[dport] = cyc;
        check({pn, ".err"}, rsp.err, exp_rsp[dport].err);
        // Write data return is don't care
        if (!exp_write[dport])
          check({pn, ".rdata"}, rsp.rdata, exp_rsp[dport].rdata);
        if (exp_lat[dport] >= 0)
          check({pn, " latency"}, cyc - issue_cyc[dport], exp_lat[dport]);
        if (exp_tgt[dport] == DEBUG)
        begin
          check("o_apb.paddr", last_paddr, exp_addr[dport][APB_AW-1:0]);
          check("o_apb.pwrite", last_pwrite, exp_write[dport]);
          if (exp_write[dport])
            check("o_apb.pwdata", last_pwdata, exp_wdata[dport]);
        end
        if ((exp_tgt[dport] == TOHOST) && exp_write[dport])
          check("o_tohost", tohost, exp_wdata[dport]);
      end
    end
  endtask

  // Sampled before the edge updates any register
  always @(posedge clk)
  begin
    if (reset_n)
    begin
      compare_port(1'b0, imem_rsp);
      compare_port(1'b1, dmem_rsp);
    end
    cyc++;
  end

  // ============================================================
  //  Stimulus helpers driven on a falling edge
  // ============================================================
  task automatic issue(input logic dport, input logic [XLEN-1:0] addr, input logic write,
                       input logic [XLEN-1:0] wdata);
    target_e tgt;
    tgt              = ref_target(addr, debug_mode, dport);
    exp_rsp[dport]   = ref_rsp(addr, debug_mode, dport);
    exp_write[dport] = write;
    exp_tgt[dport]   = tgt;
    exp_addr[dport]  = addr;
    exp_wdata[dport] = wdata;
    issue_cyc[dport] = cyc;
    if (tgt == RAM)
      exp_lat[dport] = write ? 0 : (strict_lat ? 2 : -1);
    else if (tgt == DEBUG)
      exp_lat[dport] = -1;
    else
      exp_lat[dport] = 1;
    if (write && (tgt == RAM))
      shadow_ram[addr[RAM_OFS_BITS-1:2]] = wdata;
    if (write && (tgt == TOHOST))
      tohost_shadow = wdata;
    pend[dport] = 1'b1;
    if (dport)
      dmem = '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
    else
      imem = '{valid: 1'b1, addr: addr};
  endtask

  // One full request that returns on the falling edge after done
  task automatic bus_access(input logic dport, input logic [XLEN-1:0] addr,
                            input logic write, input logic [XLEN-1:0] wdata);
    int n;
    issue(dport, addr, write, wdata);
    n = 0;
    while (pend[dport] && (n < 100))
    begin
      @(negedge clk);
      n++;
    end
    if (pend[dport])
    begin
      errors++;
      $display("ERROR: %s port got no done for address 0x%08h within 100 cycles",
               dport ? "data" : "instruction", addr);
      pend[dport] = 1'b0;
    end
    if (dport)
      dmem.valid = 1'b0;
    else
      imem.valid = 1'b0;
  endtask

  task automatic check_quiet();
    check("imem_rsp.done", imem_rsp.done, 0);
    check("dmem_rsp.done", dmem_rsp.done, 0);
    check("o_apb.psel", apb_req.psel, 0);
    check("o_apb.penable", apb_req.penable, 0);
    check("o_tohost", tohost, 0);
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == test_err0)
      $display("test %-16s ok", name);
    else
      $display("test %-16s failed, %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  // ============================================================
  //  Tests
  // ============================================================
  task automatic reset_checks();
    repeat (10)
    begin
      @(negedge clk);
      check_quiet();
    end
    reset_n = 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      check_quiet();
    end
    report_test("reset");
  endtask

  task automatic ram_data_port();
    int unsigned w;
    strict_lat = 1'b1;
    for (int k = 0; k < 8; k++)
    begin
      w = $urandom % RAM_WORDS;
      bus_access(1'b1, RAM_BASE + (w << 2), 1'b1, $urandom);
      bus_access(1'b1, RAM_BASE + (w << 2), 1'b0, '0);
      bus_access(1'b1, {RAM_ALIAS_TAG, 14'h0} + (w << 2), 1'b0, '0);
      // Alias write seen through the base window
      bus_access(1'b1, {RAM_ALIAS_TAG, 14'h0} + (w << 2), 1'b1, $urandom);
      bus_access(1'b1, RAM_BASE + (w << 2), 1'b0, '0);
    end
    strict_lat = 1'b0;
    report_test("ram data port");
  endtask

  task automatic ram_contention();
    logic [XLEN-1:0] ia;
    logic [XLEN-1:0] da;
    logic            wr;
    // Fetch words 0..63 and data words 256..319 stay disjoint
    for (int k = 0; k < 64; k++)
    begin
      bus_access(1'b1, RAM_BASE + (k << 2), 1'b1, $urandom);
      bus_access(1'b1, RAM_BASE + ((256 + k) << 2), 1'b1, $urandom);
    end
    for (int k = 0; k < 64; k++)
      bus_access(1'b0, RAM_BASE + (k << 2), 1'b0, '0);
    fork
      for (int k = 0; k < 40; k++)
      begin
        ia = (($urandom % 2) ? {RAM_ALIAS_TAG, 14'h0} : RAM_BASE) + (($urandom % 64) << 2);
        bus_access(1'b0, ia, 1'b0, '0);
      end
      for (int k = 0; k < 40; k++)
      begin
        da = RAM_BASE + ((256 + ($urandom % 64)) << 2);
        wr = $urandom % 2;
        bus_access(1'b1, da, wr, $urandom);
      end
    join
    report_test("ram contention");
  endtask

  task automatic debug_window();
    logic [XLEN-1:0] a;
    debug_mode = 1'b1;
    for (int k = 0; k < 12; k++)
    begin
      // Word aligned from 0x200 to 0xFF8
      a = DBG_START + (($urandom % 32'h37F) << 2);
      bus_access(1'b1, a, 1'b1, $urandom);
      bus_access(1'b1, a, 1'b0, '0);
      bus_access(1'b0, a, 1'b0, '0);
    end
    fork
      bus_access(1'b1, 32'h300, 1'b1, $urandom);
      bus_access(1'b0, 32'h400, 1'b0, '0);
    join
    check("dmem done before imem done", done_cyc[1] < done_cyc[0], 1);
    // Same window outside debug mode is unmapped
    debug_mode = 1'b0;
    bus_access(1'b1, 32'h200, 1'b0, '0);
    bus_access(1'b1, 32'h800, 1'b1, $urandom);
    bus_access(1'b0, 32'hFF8, 1'b0, '0);
    report_test("debug window");
  endtask

  task automatic apb_slave_error();
    debug_mode = 1'b1;
    bus_access(1'b1, 32'hFFC, 1'b0, '0);
    bus_access(1'b1, 32'hFFC, 1'b1, $urandom);
    bus_access(1'b0, 32'hFFC, 1'b0, '0);
    debug_mode = 1'b0;
    report_test("apb slave error");
  endtask

  task automatic tohost_unmapped();
    for (int k = 0; k < 4; k++)
    begin
      bus_access(1'b1, TOHOST_ADDR, 1'b1, $urandom);
      bus_access(1'b1, TOHOST_ADDR, 1'b0, '0);
    end
    check("o_tohost", tohost, tohost_shadow);
    bus_access(1'b1, 32'h0000_0000, 1'b0, '0);
    bus_access(1'b1, 32'h4000_0000, 1'b1, $urandom);
    // Tohost is not visible to fetches
    bus_access(1'b0, TOHOST_ADDR, 1'b0, '0);
    bus_access(1'b0, 32'h0002_0000, 1'b0, '0);
    report_test("tohost unmapped");
  endtask

  initial
  begin
    void'($urandom(32'h57b255dd));
    clk           = 1'b0;
    reset_n       = 1'b0;
    imem          = '0;
    dmem          = '0;
    debug_mode    = 1'b0;
    apb_rsp       = '0;
    tohost_shadow = '0;
    strict_lat    = 1'b0;
    in_access     = 1'b0;
    wait_left     = 0;
    last_paddr    = '0;
    last_pwrite   = 1'b0;
    last_pwdata   = '0;
    cyc           = 0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    test_err0     = 0;
    pend[0]       = 1'b0;
    pend[1]       = 1'b0;
    // Debug module contents unique per word
    for (int k = 0; k < 1024; k++)
      apb_mem[k] = {6'h2d, k[9:0], 6'h15, ~k[9:0]};

    reset_checks();
    ram_data_port();
    ram_contention();
    debug_window();
    apb_slave_error();
    tohost_unmapped();

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // Whole run limit
  initial
  begin
    #(2_000_000);
    $display("ERROR: simulation did not finish within the time limit");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* testbench/hart_mem_sva.sv */
/* Protocol assertions for the hart memory fabric: APB master phases
   and port done strobes around reset, bound into the top level */
`timescale 1ns/100ps

module hart_mem_sva (
  input logic                    clk,
  input logic                    reset_n,
  input hart_mem_pkg::apb_req_t  i_apb_req,
  input hart_mem_pkg::apb_rsp_t  i_apb_rsp,
  input hart_mem_pkg::mem_rsp_t  i_imem_rsp,
  input hart_mem_pkg::mem_rsp_t  i_dmem_rsp
);

  // Access phase only inside a selected transfer
  penable_needs_psel: assert property (@(posedge clk) disable iff (!reset_n)
    i_apb_req.penable |-> i_apb_req.psel)
    else $error("penable high without psel");

  // Every transfer opens with a setup phase
  psel_rise_in_setup: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(i_apb_req.psel) |-> !i_apb_req.penable)
    else $error("psel rose together with penable");

  // Address held until the slave completes
  paddr_stable: assert property (@(posedge clk) disable iff (!reset_n)
    (i_apb_req.psel && !i_apb_rsp.pready) |=> $stable(i_apb_req.paddr))
    else $error("paddr changed during a transfer");

  // No completion while in reset or on the first edge out of it
  done_low_in_reset: assert property (@(posedge clk)
    !reset_n |-> (!i_imem_rsp.done && !i_dmem_rsp.done))
    else $error("done pulsed during reset");

  done_low_after_reset: assert property (@(posedge clk)
    $rose(reset_n) |-> (!i_imem_rsp.done && !i_dmem_rsp.done))
    else $error("done pulsed right after reset");

endmodule

bind hart_mem_top hart_mem_sva u_sva (
  .clk        (clk),
  .reset_n    (reset_n),
  .i_apb_req  (o_apb),
  .i_apb_rsp  (i_apb),
  .i_imem_rsp (o_imem_rsp),
  .i_dmem_rsp (o_dmem_rsp)
);

/* rtl/hart_mem_top.sv */
/* Hart memory fabric top: address router, shared program RAM and
   debug APB master between the hart ports and the debug module */
`timescale 1ns/100ps

module hart_mem_top (
  input  logic                     clk,
  input  logic                     reset_n,
  input  hart_mem_pkg::imem_req_t  i_imem,
  input  hart_mem_pkg::dmem_req_t  i_dmem,
  input  logic                     i_debug_mode,
  input  hart_mem_pkg::apb_rsp_t   i_apb,
  output hart_mem_pkg::mem_rsp_t   o_imem_rsp,
  output hart_mem_pkg::mem_rsp_t   o_dmem_rsp,
  output hart_mem_pkg::apb_req_t   o_apb,
  output logic [31:0]              o_tohost
);
  import hart_mem_pkg::*;

  // Router to RAM
  imem_req_t ram_ireq;
  dmem_req_t ram_dreq;
  mem_rsp_t  ram_irsp;
  mem_rsp_t  ram_drsp;
  // Router to APB master
  imem_req_t dbg_ireq;
  dmem_req_t dbg_dreq;
  mem_rsp_t  dbg_irsp;
  mem_rsp_t  dbg_drsp;

  hart_bus_router u_router (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_imem       (i_imem),
    .i_dmem       (i_dmem),
    .i_debug_mode (i_debug_mode),
    .i_ram_irsp   (ram_irsp),
    .i_ram_drsp   (ram_drsp),
    .i_dbg_irsp   (dbg_irsp),
    .i_dbg_drsp   (dbg_drsp),
    .o_ram_ireq   (ram_ireq),
    .o_ram_dreq   (ram_dreq),
    .o_dbg_ireq   (dbg_ireq),
    .o_dbg_dreq   (dbg_dreq),
    .o_imem_rsp   (o_imem_rsp),
    .o_dmem_rsp   (o_dmem_rsp),
    .o_tohost     (o_tohost)
  );

  unified_ram u_ram (
    .clk     (clk),
    .reset_n (reset_n),
    .i_ireq  (ram_ireq),
    .i_dreq  (ram_dreq),
    .o_irsp  (ram_irsp),
    .o_drsp  (ram_drsp)
  );

  debug_apb_master u_apb (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_debug_mode (i_debug_mode),
    .i_ireq       (dbg_ireq),
    .i_dreq       (dbg_dreq),
    .i_apb        (i_apb),
    .o_irsp       (dbg_irsp),
    .o_drsp       (dbg_drsp),
    .o_apb        (o_apb)
  );

endmodule

/* rtl/debug_apb_master.sv */
/* APB master toward the debug module, shared by the instruction and data
   ports with the data port first; forced idle outside debug mode */
`timescale 1ns/100ps

module debug_apb_master (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     i_debug_mode,
  input  hart_mem_pkg::imem_req_t  i_ireq,
  input  hart_mem_pkg::dmem_req_t  i_dreq,
  input  hart_mem_pkg::apb_rsp_t   i_apb,
  output hart_mem_pkg::mem_rsp_t   o_irsp,
  output hart_mem_pkg::mem_rsp_t   o_drsp,
  output hart_mem_pkg::apb_req_t   o_apb
);
  import hart_mem_pkg::*;

  apb_state_e        state_q;
  apb_state_e        state_d;

  // Transfer owner, 1 for the data port
  logic              owner_d_q;
  logic              accept_d;
  logic              accept_i;
  // Last cycle of the access phase
  logic              xfer_done;

  // Captured transfer
  logic [APB_AW-1:0] paddr_q;
  logic              pwrite_q;
  logic [XLEN-1:0]   pwdata_q;

  // ============================================================
  //  Acceptance and FSM
  // ============================================================
  // Fetch waits while a data request is pending
  assign accept_d  = (state_q == IDLE) && i_debug_mode && i_dreq.valid;
  assign accept_i  = (state_q == IDLE) && i_debug_mode && i_ireq.valid &&
                     !i_dreq.valid;
  assign xfer_done = (state_q == ACCESS) && i_apb.pready;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (accept_d || accept_i)
          state_d = SETUP;
      SETUP:
        state_d = ACCESS;
      ACCESS:
        // Wait states held here until pready
        if (i_apb.pready)
          state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q   <= IDLE;
      owner_d_q <= 1'b0;
    end
    else if (!i_debug_mode)
    begin
      // Leaving debug mode abandons any transfer
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
      if (accept_d || accept_i)
        owner_d_q <= accept_d;
    end
  end

  // Address, direction and write data latched on acceptance
  always_ff @(posedge clk)
  begin
    if (accept_d)
    begin
      paddr_q  <= i_dreq.addr[APB_AW-1:0];
      pwrite_q <= i_dreq.write;
      pwdata_q <= i_dreq.wdata;
    end
    else if (accept_i)
    begin
      paddr_q  <= i_ireq.addr[APB_AW-1:0];
      pwrite_q <= 1'b0;
      pwdata_q <= '0;
    end
  end

  // ============================================================
  //  APB outputs
  // ============================================================
  // psel from SETUP on, penable in ACCESS only
  assign o_apb = '{psel:    (state_q != IDLE),
                   penable: (state_q == ACCESS),
                   pwrite:  pwrite_q,
                   paddr:   paddr_q,
                   pwdata:  pwdata_q};

  // ============================================================
  //  Port responses
  // ============================================================
  // Completion in the pready cycle, only to the owner
  assign o_drsp = '{done:  xfer_done && owner_d_q,
                    err:   xfer_done && owner_d_q && i_apb.pslverr,
                    rdata: i_apb.prdata};
  assign o_irsp = '{done:  xfer_done && !owner_d_q,
                    err:   xfer_done && !owner_d_q && i_apb.pslverr,
                    rdata: i_apb.prdata};

endmodule

/* rtl/unified_ram.sv */
/* Single-port program RAM shared by instruction and data ports,
   data writes first, then data reads, then fetches; two-edge read return */
`timescale 1ns/100ps

module unified_ram (
  input  logic                     clk,
  input  logic                     reset_n,
  input  hart_mem_pkg::imem_req_t  i_ireq,
  input  hart_mem_pkg::dmem_req_t  i_dreq,
  output hart_mem_pkg::mem_rsp_t   o_irsp,
  output hart_mem_pkg::mem_rsp_t   o_drsp
);
  import hart_mem_pkg::*;

  logic [XLEN-1:0]   mem [RAM_WORDS];

  // Arbiter result for this cycle and the one before
  ram_grant_e        gnt;
  ram_grant_e        gnt_q;
  // Read in flight per port, set at grant, cleared after done
  logic              ibusy_q;
  logic              dbusy_q;
  logic [RAM_AW-1:0] ram_addr;
  // Array output, first read edge
  logic [XLEN-1:0]   rd_q;
  // Output registers, second read edge
  logic              idone_q;
  logic              ddone_q;
  logic [XLEN-1:0]   irdata_q;
  logic [XLEN-1:0]   drdata_q;

  // ============================================================
  //  Arbiter
  // ============================================================
  always_comb
  begin
    gnt = NONE;
    // Data writes are never refused
    if (i_dreq.valid && i_dreq.write)
      gnt = DWR;
    else if (i_dreq.valid && !dbusy_q)
      gnt = DRD;
    else if (i_ireq.valid && !ibusy_q)
      gnt = IRD;
  end

  // Word address from bits 13..2, same for base window and alias
  assign ram_addr = (gnt == IRD) ? i_ireq.addr[RAM_OFS_BITS-1:2] :
                                   i_dreq.addr[RAM_OFS_BITS-1:2];

  // ============================================================
  //  Array and read pipeline
  // ============================================================
  always_ff @(posedge clk)
  begin
    if (gnt == DWR)
      mem[ram_addr] <= i_dreq.wdata;
    else if ((gnt == DRD) || (gnt == IRD))
      rd_q <= mem[ram_addr];

    // Steer array data to the port that owned the previous cycle
    if (gnt_q == IRD)
      irdata_q <= rd_q;
    if (gnt_q == DRD)
      drdata_q <= rd_q;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      gnt_q   <= NONE;
      ibusy_q <= 1'b0;
      dbusy_q <= 1'b0;
      idone_q <= 1'b0;
      ddone_q <= 1'b0;
    end
    else
    begin
      gnt_q   <= gnt;
      idone_q <= (gnt_q == IRD);
      ddone_q <= (gnt_q == DRD);

      // Busy spans the done cycle too, the request is still held there
      if (gnt == IRD)
        ibusy_q <= 1'b1;
      else if (idone_q)
        ibusy_q <= 1'b0;

      if (gnt == DRD)
        dbusy_q <= 1'b1;
      else if (ddone_q)
        dbusy_q <= 1'b0;
    end
  end

  // ============================================================
  //  Responses
  // ============================================================
  assign o_irsp = '{done: idone_q, err: 1'b0, rdata: irdata_q};
  // Write completes in its request cycle
  assign o_drsp = '{done: ddone_q || (gnt == DWR), err: 1'b0, rdata: drdata_q};

endmodule

/* rtl/hart_bus_router.sv */
/* Address decoder and response merger for the hart instruction and data
   ports; also answers tohost and unmapped accesses and holds tohost */
`timescale 1ns/100ps

module hart_bus_router (
  input  logic                     clk,
  input  logic                     reset_n,
  input  hart_mem_pkg::imem_req_t  i_imem,
  input  hart_mem_pkg::dmem_req_t  i_dmem,
  input  logic                     i_debug_mode,
  input  hart_mem_pkg::mem_rsp_t   i_ram_irsp,
  input  hart_mem_pkg::mem_rsp_t   i_ram_drsp,
  input  hart_mem_pkg::mem_rsp_t   i_dbg_irsp,
  input  hart_mem_pkg::mem_rsp_t   i_dbg_drsp,
  output hart_mem_pkg::imem_req_t  o_ram_ireq,
  output hart_mem_pkg::dmem_req_t  o_ram_dreq,
  output hart_mem_pkg::imem_req_t  o_dbg_ireq,
  output hart_mem_pkg::dmem_req_t  o_dbg_dreq,
  output hart_mem_pkg::mem_rsp_t   o_imem_rsp,
  output hart_mem_pkg::mem_rsp_t   o_dmem_rsp,
  output logic [31:0]              o_tohost
);
  import hart_mem_pkg::*;

  // Decoded targets of the two ports
  target_e         itgt;
  target_e         dtgt;
  // One-cycle local responders
  logic            iloc_start;
  logic            iloc_done_q;
  logic            dloc_start;
  logic            dloc_done_q;
  logic            dloc_err_q;
  logic [XLEN-1:0] dloc_rdata_q;
  logic [XLEN-1:0] tohost_q;

  // Debug region first, then RAM window or alias, then tohost
  function automatic target_e decode_addr(input logic [XLEN-1:0] addr,
                                          input logic            dbg_mode,
                                          input logic            data_port);
    target_e tgt;
    tgt = UNMAPPED;
    if (dbg_mode && (addr >= DBG_START) && (addr <= DBG_END))
      tgt = DEBUG;
    else if ((addr[XLEN-1:RAM_OFS_BITS] == RAM_BASE[XLEN-1:RAM_OFS_BITS]) ||
             (addr[XLEN-1:RAM_OFS_BITS] == RAM_ALIAS_TAG))
      tgt = RAM;
    else if (data_port && (addr == TOHOST_ADDR))
      tgt = TOHOST;
    return tgt;
  endfunction

  assign itgt = decode_addr(i_imem.addr, i_debug_mode, 1'b0);
  assign dtgt = decode_addr(i_dmem.addr, i_debug_mode, 1'b1);

  // ============================================================
  //  Request steering
  // ============================================================
  // Payload goes everywhere, valid only to the selected target
  always_comb
  begin
    o_ram_ireq       = i_imem;
    o_ram_ireq.valid = i_imem.valid && (itgt == RAM);
    o_dbg_ireq       = i_imem;
    o_dbg_ireq.valid = i_imem.valid && (itgt == DEBUG);
    o_ram_dreq       = i_dmem;
    o_ram_dreq.valid = i_dmem.valid && (dtgt == RAM);
    o_dbg_dreq       = i_dmem;
    o_dbg_dreq.valid = i_dmem.valid && (dtgt == DEBUG);
  end

  // ============================================================
  //  Tohost and unmapped responders
  // ============================================================
  // Blocked during the done cycle, the request is still held there
  assign iloc_start = i_imem.valid && (itgt == UNMAPPED) && !iloc_done_q;
  assign dloc_start = i_dmem.valid && ((dtgt == TOHOST) || (dtgt == UNMAPPED)) &&
                      !dloc_done_q;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      iloc_done_q <= 1'b0;
      dloc_done_q <= 1'b0;
      dloc_err_q  <= 1'b0;
      tohost_q    <= '0;
    end
    else
    begin
      iloc_done_q <= iloc_start;
      dloc_done_q <= dloc_start;
      dloc_err_q  <= dloc_start && (dtgt == UNMAPPED);
      // Test program result lands at the request edge
      if (dloc_start && (dtgt == TOHOST) && i_dmem.write)
        tohost_q <= i_dmem.wdata;
    end
  end

  // Read data: tohost value, zero for unmapped
  always_ff @(posedge clk)
  begin
    if (dloc_start)
      dloc_rdata_q <= (dtgt == TOHOST) ? tohost_q : '0;
  end

  assign o_tohost = tohost_q;

  // ============================================================
  //  Response merge
  // ============================================================
  always_comb
  begin
    case (itgt)
      // RAM never reports an error
      RAM:     o_imem_rsp = '{done: i_ram_irsp.done, err: 1'b0, rdata: i_ram_irsp.rdata};
      DEBUG:   o_imem_rsp = i_dbg_irsp;
      default: o_imem_rsp = '{done: iloc_done_q, err: iloc_done_q, rdata: '0};
    endcase

    case (dtgt)
      RAM:     o_dmem_rsp = '{done: i_ram_drsp.done, err: 1'b0, rdata: i_ram_drsp.rdata};
      DEBUG:   o_dmem_rsp = i_dbg_drsp;
      default: o_dmem_rsp = '{done: dloc_done_q, err: dloc_err_q, rdata: dloc_rdata_q};
    endcase
  end

endmodule

/* rtl/hart_mem_pkg.sv */
/* Hart memory fabric definitions: memory map, bus widths, state and
   target encodings, and the request/response structs shared by all blocks */
package hart_mem_pkg;

  // ============================================================
  //  Widths
  // ============================================================
  localparam int XLEN         = 32;
  // Word address width of the program RAM
  localparam int RAM_AW       = 12;
  localparam int RAM_WORDS    = 4096;
  // Byte offset bits covered by the RAM window (16 KB)
  localparam int RAM_OFS_BITS = 14;
  // Debug module APB address width
  localparam int APB_AW       = 13;

  // ============================================================
  //  Memory map
  // ============================================================
  // Program RAM base window, 0x10000 to 0x13FFF
  localparam logic [XLEN-1:0] RAM_BASE = 32'h0001_0000;
  // Upper address bits of the 0xFFFFC000 alias of the RAM
  localparam logic [XLEN-RAM_OFS_BITS-1:0] RAM_ALIAS_TAG = 18'h3_FFFF;
  // Debug module region, reachable in debug mode only
  localparam logic [XLEN-1:0] DBG_START = 32'h0000_0200;
  localparam logic [XLEN-1:0] DBG_END   = 32'h0000_0FFF;
  // Test result register, data port only
  localparam logic [XLEN-1:0] TOHOST_ADDR = 32'h8000_1000;

  // ============================================================
  //  Encodings
  // ============================================================
  // Decoded destination of one request
  typedef enum logic [1:0] {
    RAM,
    DEBUG,
    TOHOST,
    UNMAPPED
  } target_e;

  // APB master phases
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

  // Owner of the single RAM port in one cycle
  typedef enum logic [1:0] {
    NONE,
    DWR,
    DRD,
    IRD
  } ram_grant_e;

  // ============================================================
  //  Request and response structs
  // ============================================================
  // Instruction fetch, held until done
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
  } imem_req_t;

  // Data load or store, held until done
  typedef struct packed {
    logic            valid;
    logic            write;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } dmem_req_t;

  // Completion strobe with error flag and read data
  typedef struct packed {
    logic            done;
    logic            err;
    logic [XLEN-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [XLEN-1:0]   pwdata;
  } apb_req_t;

  typedef struct packed {
    logic            pready;
    logic            pslverr;
    logic [XLEN-1:0] prdata;
  } apb_rsp_t;

endpackage
